/* cpu_ctrl_macros.svh */
`ifndef CPU_CTRL_MACROS_SVH
`define CPU_CTRL_MACROS_SVH

// --------------------------------------------------
// Bus geometry
// --------------------------------------------------

// AXI4-Lite address and data widths
`define CPU_CTRL_ADDR_W 16
`define CPU_CTRL_DATA_W 32

// Number of general registers exported by the core
`define CPU_CTRL_NUM_GPR 32

// --------------------------------------------------
// Register map
// --------------------------------------------------

// Control words
`define CPU_CTRL_REG_RESET 16'h0000
`define CPU_CTRL_REG_RUN 16'h0004

// Core state window, one word per general register
`define CPU_CTRL_GPR_BASE 16'h1000
`define CPU_CTRL_REG_PC 16'h1080

// Flops in each core line feedback synchronizer
`define CPU_CTRL_SYNC_STAGES 2

`endif

/* cpu_ctrl_pkg.sv */
`default_nettype none

`include "cpu_ctrl_macros.svh"

package cpu_ctrl_pkg;

    // --------------------------------------------------
    // Core observation
    // --------------------------------------------------

    // Snapshot of the core as seen by the host
    // gpr[0] holds register 0, pc sits in the low word
    typedef struct packed {
        logic [`CPU_CTRL_NUM_GPR-1:0][`CPU_CTRL_DATA_W-1:0] gpr;
        logic [`CPU_CTRL_DATA_W-1:0]                        pc;
    } core_state_t;

    // --------------------------------------------------
    // Bus to register map
    // --------------------------------------------------

    // One accepted write
    // Valid only in the handshake cycle
    typedef struct packed {
        logic                        valid;
        logic [`CPU_CTRL_ADDR_W-1:0] addr;
        logic [`CPU_CTRL_DATA_W-1:0] data;
    } reg_wr_t;

    // One accepted read request
    // Address stays latched, valid marks the arready cycle
    typedef struct packed {
        logic                        valid;
        logic [`CPU_CTRL_ADDR_W-1:0] addr;
    } reg_rd_t;

endpackage

`default_nettype wire

/* axi_lite_slave.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_ctrl_macros.svh"

module axi_lite_slave (
    input  wire logic                            S_AXI_ACLK,
    input  wire logic                            cache_slv_reg0,
    // Write address channel
    input  wire logic [`CPU_CTRL_ADDR_W-1:0]     s_axi_awaddr,
    input  wire logic [2:0]                      s_axi_awprot,
    input  wire logic                            s_axi_awvalid,
    output logic                                 s_axi_awready,
    // Write data channel
    input  wire logic [`CPU_CTRL_DATA_W-1:0]     s_axi_wdata,
    input  wire logic [`CPU_CTRL_DATA_W/8-1:0]   s_axi_wstrb,
    input  wire logic                            s_axi_wvalid,
    output logic                                 s_axi_wready,
    // Write response channel
    output logic [1:0]                           s_axi_bresp,
    output logic                                 s_axi_bvalid,
    input  wire logic                            s_axi_bready,
    // Read address channel
    input  wire logic [`CPU_CTRL_ADDR_W-1:0]     s_axi_araddr,
    input  wire logic [2:0]                      s_axi_arprot,
    input  wire logic                            s_axi_arvalid,
    output logic                                 s_axi_arready,
    // Read data channel
    output logic [`CPU_CTRL_DATA_W-1:0]          s_axi_rdata,
    output logic [1:0]                           s_axi_rresp,
    output logic                                 s_axi_rvalid,
    input  wire logic                            s_axi_rready,
    // Register map side
    output cpu_ctrl_pkg::reg_wr_t                reg_wr,
    output cpu_ctrl_pkg::reg_rd_t                reg_rd,
    input  wire logic [`CPU_CTRL_DATA_W-1:0]     rd_data
);

    // Write side state
    logic                        aw_en;
    logic                        wr_ready_q;
    logic                        bvalid_q;
    logic [`CPU_CTRL_ADDR_W-1:0] awaddr_q;
    // Read side state
    logic                        arready_q;
    logic                        rvalid_q;
    logic [`CPU_CTRL_ADDR_W-1:0] araddr_q;
    logic [`CPU_CTRL_DATA_W-1:0] rdata_q;
    logic                        wr_accept;
    logic                        wr_fire;
    logic                        rd_fire;

    // --------------------------------------------------
    // Write channels
    // --------------------------------------------------

    // Both valids present and nothing outstanding
    assign wr_accept = ~wr_ready_q && s_axi_awvalid && s_axi_wvalid && aw_en;
    // Address and data taken together
    assign wr_fire   = wr_ready_q && s_axi_awvalid && s_axi_wvalid;

    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
        begin
            wr_ready_q <= 1'b0;
            aw_en      <= 1'b1;
        end
        else if (wr_accept)
        begin
            wr_ready_q <= 1'b1;
            aw_en      <= 1'b0;
        end
        else
        begin
            wr_ready_q <= 1'b0;
            // Reopen once the response has gone out
            if (s_axi_bready && bvalid_q)
                aw_en <= 1'b1;
        end
    end

    // Address held for the handshake cycle
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (wr_accept)
            awaddr_q <= s_axi_awaddr;
    end

    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
            bvalid_q <= 1'b0;
        else if (wr_fire)
            bvalid_q <= 1'b1;
        else if (s_axi_bready)
            bvalid_q <= 1'b0;
    end

    // --------------------------------------------------
    // Read channels
    // --------------------------------------------------

    assign rd_fire = arready_q && s_axi_arvalid;

    // New address only while no read data is pending
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
            arready_q <= 1'b0;
        else
            arready_q <= ~arready_q && s_axi_arvalid && ~rvalid_q;
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (~arready_q && s_axi_arvalid && ~rvalid_q)
            araddr_q <= s_axi_araddr;
    end

    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
            rvalid_q <= 1'b0;
        else if (rd_fire)
            rvalid_q <= 1'b1;
        else if (s_axi_rready)
            rvalid_q <= 1'b0;
    end

    // Decoded word captured at the address handshake
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_fire)
            rdata_q <= rd_data;
    end

    // Outputs, responses always OKAY
    assign s_axi_awready = wr_ready_q;
    assign s_axi_wready  = wr_ready_q;
    assign s_axi_bresp   = 2'b00;
    assign s_axi_bvalid  = bvalid_q;
    assign s_axi_arready = arready_q;
    assign s_axi_rdata   = rdata_q;
    assign s_axi_rresp   = 2'b00;
    assign s_axi_rvalid  = rvalid_q;

    assign reg_wr.valid = wr_fire;
    assign reg_wr.addr  = awaddr_q;
    assign reg_wr.data  = s_axi_wdata;
    assign reg_rd.valid = rd_fire;
    assign reg_rd.addr  = araddr_q;

endmodule

`default_nettype wire

/* ctrl_regmap.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_ctrl_macros.svh"

module ctrl_regmap (
    input  wire logic                        S_AXI_ACLK,
    input  wire logic                        cache_slv_reg0,
    input  wire cpu_ctrl_pkg::reg_wr_t       reg_wr,
    input  wire cpu_ctrl_pkg::reg_rd_t       reg_rd,
    input  wire cpu_ctrl_pkg::core_state_t   core_state,
    output logic [`CPU_CTRL_DATA_W-1:0]      rd_data,
    output logic                             reset_set,
    output logic                             run_set
);

    localparam int GPR_IDX_W = $clog2(`CPU_CTRL_NUM_GPR);

    logic [`CPU_CTRL_DATA_W-1:0] run_word;
    logic                        wr_reset;
    logic                        wr_run;
    // Read decode helpers
    logic [`CPU_CTRL_ADDR_W-1:0] gpr_off;
    logic [GPR_IDX_W-1:0]        gpr_idx;
    logic                        gpr_hit;

    // --------------------------------------------------
    // Control words
    // --------------------------------------------------

    assign wr_reset = reg_wr.valid && (reg_wr.addr == `CPU_CTRL_REG_RESET);
    assign wr_run   = reg_wr.valid && (reg_wr.addr == `CPU_CTRL_REG_RUN);

    // Run word keeps its value until rewritten
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
            run_word <= '0;
        else if (wr_run)
            run_word <= reg_wr.data;
    end

    // Reset word is not stored
    // Non-zero write gives a single cycle request
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
            reset_set <= 1'b0;
        else
            reset_set <= wr_reset && (reg_wr.data != '0);
    end

    // Execute requested while any run bit is set
    assign run_set = |run_word;

    // --------------------------------------------------
    // Read decode
    // --------------------------------------------------

    // Offset into the register window, wraps below the base
    assign gpr_off = reg_rd.addr - `CPU_CTRL_GPR_BASE;
    assign gpr_idx = gpr_off[GPR_IDX_W+1:2];
    // Word aligned and inside the window
    assign gpr_hit = (gpr_off[`CPU_CTRL_ADDR_W-1:2] < `CPU_CTRL_NUM_GPR) &&
                     (gpr_off[1:0] == 2'b00);

    // Unmapped addresses and the reset word read as zero
    always_comb
    begin
        rd_data = '0;
        if (reg_rd.valid)
        begin
            if (reg_rd.addr == `CPU_CTRL_REG_RUN)
                rd_data = run_word;
            else if (gpr_hit)
                rd_data = core_state.gpr[gpr_idx];
            else if (reg_rd.addr == `CPU_CTRL_REG_PC)
                rd_data = core_state.pc;
        end
    end

endmodule

`default_nettype wire

/* core_cmd_sync.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_ctrl_macros.svh"

module core_cmd_sync #(
    // Request state coming out of reset
    parameter bit REQ_INIT = 1'b0
) (
    input  wire logic S_AXI_ACLK,
    input  wire logic cache_slv_reg0,
    input  wire logic cclk,
    input  wire logic set,
    output logic      line
);

    // Request flag, bus clock domain
    logic                             req;
    // Copy of line brought back into the bus clock domain
    logic [`CPU_CTRL_SYNC_STAGES-1:0] fb_sync;

    // --------------------------------------------------
    // Bus clock side
    // --------------------------------------------------

    // Feedback synchronizer, oldest sample in the top bit
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
            fb_sync <= '0;
        else
            fb_sync <= {fb_sync[`CPU_CTRL_SYNC_STAGES-2:0], line};
    end

    // Set wins over clear
    // Clear once the core side has shown the line high
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
            req <= REQ_INIT;
        else if (set)
            req <= 1'b1;
        else if (fb_sync[`CPU_CTRL_SYNC_STAGES-1])
            req <= 1'b0;
    end

    // --------------------------------------------------
    // Core clock side
    // --------------------------------------------------

    // req is quasi-static relative to cclk
    // Held until its own feedback returns
    always_ff @(posedge cclk or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
            line <= REQ_INIT;
        else
            line <= req;
    end

endmodule

`default_nettype wire

/* cpu_core_controller.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_ctrl_macros.svh"

module cpu_core_controller (
    input  wire logic                            S_AXI_ACLK,
    input  wire logic                            cache_slv_reg0,
    input  wire logic                            cclk,
    // AXI4-Lite slave
    input  wire logic [`CPU_CTRL_ADDR_W-1:0]     s_axi_awaddr,
    input  wire logic [2:0]                      s_axi_awprot,
    input  wire logic                            s_axi_awvalid,
    output wire logic                            s_axi_awready,
    input  wire logic [`CPU_CTRL_DATA_W-1:0]     s_axi_wdata,
    input  wire logic [`CPU_CTRL_DATA_W/8-1:0]   s_axi_wstrb,
    input  wire logic                            s_axi_wvalid,
    output wire logic                            s_axi_wready,
    output wire logic [1:0]                      s_axi_bresp,
    output wire logic                            s_axi_bvalid,
    input  wire logic                            s_axi_bready,
    input  wire logic [`CPU_CTRL_ADDR_W-1:0]     s_axi_araddr,
    input  wire logic [2:0]                      s_axi_arprot,
    input  wire logic                            s_axi_arvalid,
    output wire logic                            s_axi_arready,
    output wire logic [`CPU_CTRL_DATA_W-1:0]     s_axi_rdata,
    output wire logic [1:0]                      s_axi_rresp,
    output wire logic                            s_axi_rvalid,
    input  wire logic                            s_axi_rready,
    // Core side
    input  wire cpu_ctrl_pkg::core_state_t       core_state,
    output wire logic                            crst,
    output wire logic                            cexec
);

    import cpu_ctrl_pkg::*;

    reg_wr_t                     reg_wr;
    reg_rd_t                     reg_rd;
    logic [`CPU_CTRL_DATA_W-1:0] rd_data;
    logic                        reset_set;
    logic                        run_set;

    // --------------------------------------------------
    // Bus front end and register map
    // --------------------------------------------------

    axi_lite_slave u_axi (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .cache_slv_reg0 (cache_slv_reg0),
        .s_axi_awaddr   (s_axi_awaddr),
        .s_axi_awprot   (s_axi_awprot),
        .s_axi_awvalid  (s_axi_awvalid),
        .s_axi_awready  (s_axi_awready),
        .s_axi_wdata    (s_axi_wdata),
        .s_axi_wstrb    (s_axi_wstrb),
        .s_axi_wvalid   (s_axi_wvalid),
        .s_axi_wready   (s_axi_wready),
        .s_axi_bresp    (s_axi_bresp),
        .s_axi_bvalid   (s_axi_bvalid),
        .s_axi_bready   (s_axi_bready),
        .s_axi_araddr   (s_axi_araddr),
        .s_axi_arprot   (s_axi_arprot),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rready   (s_axi_rready),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .rd_data        (rd_data)
    );

    ctrl_regmap u_regmap (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .cache_slv_reg0 (cache_slv_reg0),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .core_state     (core_state),
        .rd_data        (rd_data),
        .reset_set      (reset_set),
        .run_set        (run_set)
    );

    // --------------------------------------------------
    // Core command lines
    // --------------------------------------------------

    // Core held in reset from power up until the line is seen
    core_cmd_sync #(.REQ_INIT(1'b1)) u_crst (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .cache_slv_reg0 (cache_slv_reg0),
        .cclk           (cclk),
        .set            (reset_set),
        .line           (crst)
    );

    core_cmd_sync #(.REQ_INIT(1'b0)) u_cexec (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .cache_slv_reg0 (cache_slv_reg0),
        .cclk           (cclk),
        .set            (run_set),
        .line           (cexec)
    );

endmodule

`default_nettype wire

/* cpu_ctrl_sva.sv */
`default_nettype none
`timescale 1ns/10ps

module cpu_ctrl_sva (
    input wire logic S_AXI_ACLK,
    input wire logic cache_slv_reg0,
    input wire logic s_axi_awready,
    input wire logic s_axi_wready,
    input wire logic s_axi_bvalid,
    input wire logic s_axi_bready,
    input wire logic s_axi_rvalid,
    input wire logic s_axi_rready,
    input wire logic crst,
    input wire logic cexec
);

    // --------------------------------------------------
    // Bus handshake rules
    // --------------------------------------------------

    // Write response stays up until taken
    a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    // Read data stays up until taken
    a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
        else $error("rvalid dropped before rready");

    // Address and data accepted in the same cycle
    a_ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        s_axi_awready == s_axi_wready)
        else $error("awready and wready differ");

    // Write ready is a single cycle pulse
    a_ready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        s_axi_awready |=> !s_axi_awready)
        else $error("awready high for more than one cycle");

    // --------------------------------------------------
    // Core lines
    // --------------------------------------------------

    a_lines_known: assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        !$isunknown({crst, cexec}))
        else $error("crst or cexec unknown");

endmodule

bind cpu_core_controller cpu_ctrl_sva u_sva (
    .S_AXI_ACLK     (S_AXI_ACLK),
    .cache_slv_reg0 (cache_slv_reg0),
    .s_axi_awready  (s_axi_awready),
    .s_axi_wready   (s_axi_wready),
    .s_axi_bvalid   (s_axi_bvalid),
    .s_axi_bready   (s_axi_bready),
    .s_axi_rvalid   (s_axi_rvalid),
    .s_axi_rready   (s_axi_rready),
    .crst           (crst),
    .cexec          (cexec)
);

`default_nettype wire

/* tb_cpu_core_controller.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_ctrl_macros.svh"

module tb_cpu_core_controller;

    import cpu_ctrl_pkg::*;

    // Bus clock 40 ns and core clock 60 ns
    localparam int ACLK_HALF = 20;
    localparam int CCLK_HALF = 30;
    localparam int DRIVE_DLY = 2;
    localparam int RESET_CYCLES = 16;
    // Rough sum of all test lengths in bus cycles
    localparam int TEST_CYCLES = 400;
    localparam int TIMEOUT_CYCLES = 10 * TEST_CYCLES;
    localparam int LINE_CRST = 0;
    localparam int LINE_CEXEC = 1;

    logic                            S_AXI_ACLK;
    logic                            cache_slv_reg0;
    logic                            cclk;
    logic [`CPU_CTRL_ADDR_W-1:0]     s_axi_awaddr;
    logic [2:0]                      s_axi_awprot;
    logic                            s_axi_awvalid;
    logic                            s_axi_awready;
    logic [`CPU_CTRL_DATA_W-1:0]     s_axi_wdata;
    logic [`CPU_CTRL_DATA_W/8-1:0]   s_axi_wstrb;
    logic                            s_axi_wvalid;
    logic                            s_axi_wready;
    logic [1:0]                      s_axi_bresp;
    logic                            s_axi_bvalid;
    logic                            s_axi_bready;
    logic [`CPU_CTRL_ADDR_W-1:0]     s_axi_araddr;
    logic [2:0]                      s_axi_arprot;
    logic                            s_axi_arvalid;
    logic                            s_axi_arready;
    logic [`CPU_CTRL_DATA_W-1:0]     s_axi_rdata;
    logic [1:0]                      s_axi_rresp;
    logic                            s_axi_rvalid;
    logic                            s_axi_rready;
    core_state_t                     core_state;
    logic                            crst;
    logic                            cexec;

    // Expected core state with one word per register
    logic [`CPU_CTRL_DATA_W-1:0]     exp_gpr [0:`CPU_CTRL_NUM_GPR-1];
    logic [`CPU_CTRL_DATA_W-1:0]     exp_pc;
    logic [31:0]                     lcg_state;
    string                           test_name;
    int                              checks;
    int                              errors;
    int                              cycle_cnt;

    cpu_core_controller u_dut (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .cache_slv_reg0 (cache_slv_reg0),
        .cclk           (cclk),
        .s_axi_awaddr   (s_axi_awaddr),
        .s_axi_awprot   (s_axi_awprot),
        .s_axi_awvalid  (s_axi_awvalid),
        .s_axi_awready  (s_axi_awready),
        .s_axi_wdata    (s_axi_wdata),
        .s_axi_wstrb    (s_axi_wstrb),
        .s_axi_wvalid   (s_axi_wvalid),
        .s_axi_wready   (s_axi_wready),
        .s_axi_bresp    (s_axi_bresp),
        .s_axi_bvalid   (s_axi_bvalid),
        .s_axi_bready   (s_axi_bready),
        .s_axi_araddr   (s_axi_araddr),
        .s_axi_arprot   (s_axi_arprot),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rready   (s_axi_rready),
        .core_state     (core_state),
        .crst           (crst),
        .cexec          (cexec)
    );

    // --------------------------------------------------
    // Clocks and watchdog
    // --------------------------------------------------

    initial
    begin
        S_AXI_ACLK = 1'b0;
        forever #ACLK_HALF S_AXI_ACLK = ~S_AXI_ACLK;
    end

    initial
    begin
        cclk = 1'b0;
        forever #CCLK_HALF cclk = ~cclk;
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge S_AXI_ACLK);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d bus cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    // Numerical Recipes LCG constants
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic line_value(input int which);
        return (which == LINE_CRST) ? crst : cexec;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("FAILED %s %s expected %08h actual %08h",
                     test_name, what, expected, actual);
        end
    endtask

    // Step to the next drive point just after the rising edge
    task automatic next_cycle();
        @(posedge S_AXI_ACLK);
        #DRIVE_DLY;
    endtask

    // Poll a core line until it reaches a level within a cycle bound
    task automatic wait_line(input string what, input int which, input logic level,
                             input int max_cycles);
        int n;
        n = 0;
        while ((line_value(which) !== level) && (n < max_cycles))
        begin
            next_cycle();
            n++;
        end
        checks++;
        if (line_value(which) !== level)
        begin
            errors++;
            $display("%s: %s did not go to %0d within %0d cycles",
                     test_name, what, level, max_cycles);
        end
    endtask

    // Core line must keep its level for a number of cycles
    task automatic hold_line(input string what, input int which, input logic level,
                             input int cycles);
        repeat (cycles)
        begin
            next_cycle();
            check(what, 32'(level), 32'(line_value(which)));
        end
    endtask

    // --------------------------------------------------
    // AXI4-Lite bus tasks
    // --------------------------------------------------

    // hold gives the number of cycles bready stays low once bvalid is up
    task automatic axi_write(input logic [`CPU_CTRL_ADDR_W-1:0] addr,
                             input logic [`CPU_CTRL_DATA_W-1:0] data, input int hold);
        logic [1:0] resp;
        next_cycle();
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        s_axi_bready  = (hold == 0);
        while (!s_axi_awready)
            next_cycle();
        // Data channel ready in the same cycle as the address channel
        check("wready with awready", 32'd1, 32'(s_axi_wready));
        // Address and data taken on this edge
        next_cycle();
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid)
            next_cycle();
        resp = s_axi_bresp;
        check("bresp", 32'd0, 32'(resp));
        for (int i = 0; i < hold; i++)
        begin
            next_cycle();
            check("bvalid held", 32'd1, 32'(s_axi_bvalid));
            check("bresp held", 32'd0, 32'(s_axi_bresp));
        end
        s_axi_bready = 1'b1;
        next_cycle();
        s_axi_bready = 1'b0;
    endtask

    // hold gives the number of cycles rready stays low once rvalid is up
    task automatic axi_read(input logic [`CPU_CTRL_ADDR_W-1:0] addr, input int hold,
                            output logic [`CPU_CTRL_DATA_W-1:0] data,
                            output logic [1:0] resp);
        next_cycle();
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        s_axi_rready  = (hold == 0);
        while (!s_axi_arready)
            next_cycle();
        next_cycle();
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid)
            next_cycle();
        data = s_axi_rdata;
        resp = s_axi_rresp;
        for (int i = 0; i < hold; i++)
        begin
            next_cycle();
            check("rvalid held", 32'd1, 32'(s_axi_rvalid));
            check("rdata held", data, s_axi_rdata);
        end
        s_axi_rready = 1'b1;
        next_cycle();
        s_axi_rready = 1'b0;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_reset_release();
        test_name = "reset_release";
        // Core is still held in reset right after the bus reset
        check("crst after reset", 32'd1, 32'(crst));
        check("cexec after reset", 32'd0, 32'(cexec));
        wait_line("crst fall", LINE_CRST, 1'b0, 40);
        hold_line("cexec low", LINE_CEXEC, 1'b0, 10);
    endtask

    task automatic test_core_state_reads();
        logic [`CPU_CTRL_DATA_W-1:0] data;
        logic [1:0]                  resp;
        test_name = "core_state_reads";
        for (int i = 0; i < `CPU_CTRL_NUM_GPR; i++)
        begin
            axi_read(`CPU_CTRL_GPR_BASE + 16'(4 * i), 0, data, resp);
            check($sformatf("gpr %0d", i), exp_gpr[i], data);
            check("rresp", 32'd0, 32'(resp));
        end
        axi_read(`CPU_CTRL_REG_PC, 0, data, resp);
        check("pc", exp_pc, data);
        check("rresp", 32'd0, 32'(resp));
    endtask

    task automatic test_run_control();
        logic [`CPU_CTRL_DATA_W-1:0] run_val;
        logic [`CPU_CTRL_DATA_W-1:0] data;
        logic [1:0]                  resp;
        test_name = "run_control";
        lcg_state = lcg_next(lcg_state);
        // Bit 0 forced so the word is never zero
        run_val = lcg_state | 32'h1;
        axi_write(`CPU_CTRL_REG_RUN, run_val, 0);
        axi_read(`CPU_CTRL_REG_RUN, 0, data, resp);
        check("run word", run_val, data);
        wait_line("cexec rise", LINE_CEXEC, 1'b1, 20);
        hold_line("cexec high", LINE_CEXEC, 1'b1, 15);
        axi_write(`CPU_CTRL_REG_RUN, 32'h0, 0);
        wait_line("cexec fall", LINE_CEXEC, 1'b0, 20);
    endtask

    task automatic test_reset_control();
        test_name = "reset_control";
        axi_write(`CPU_CTRL_REG_RESET, 32'h1, 0);
        wait_line("crst rise", LINE_CRST, 1'b1, 20);
        wait_line("crst fall", LINE_CRST, 1'b0, 20);
        // Zero write requests nothing
        axi_write(`CPU_CTRL_REG_RESET, 32'h0, 0);
        hold_line("crst low", LINE_CRST, 1'b0, 30);
    endtask

    task automatic test_unmapped_and_backpressure();
        logic [`CPU_CTRL_DATA_W-1:0] data;
        logic [1:0]                  resp;
        test_name = "unmapped_backpressure";
        axi_read(`CPU_CTRL_REG_RESET, 0, data, resp);
        check("reset word read", 32'h0, data);
        axi_read(16'h2000, 0, data, resp);
        check("unmapped read", 32'h0, data);
        // Ten cycles of stalled responses
        axi_write(`CPU_CTRL_REG_RUN, 32'h5a5a_0001, 10);
        axi_read(`CPU_CTRL_REG_RUN, 10, data, resp);
        check("stalled read", 32'h5a5a_0001, data);
        check("stalled rresp", 32'd0, 32'(resp));
        // Channel reopens after the stall
        axi_write(`CPU_CTRL_REG_RUN, 32'h0, 0);
        axi_read(`CPU_CTRL_REG_RUN, 0, data, resp);
        check("read after stall", 32'h0, data);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial
    begin
        checks         = 0;
        errors         = 0;
        test_name      = "init";
        cache_slv_reg0 = 1'b1;
        s_axi_awaddr   = '0;
        s_axi_awprot   = 3'b000;
        s_axi_awvalid  = 1'b0;
        s_axi_wdata    = '0;
        s_axi_wstrb    = '1;
        s_axi_wvalid   = 1'b0;
        s_axi_bready   = 1'b0;
        s_axi_araddr   = '0;
        s_axi_arprot   = 3'b000;
        s_axi_arvalid  = 1'b0;
        s_axi_rready   = 1'b0;
        // Core registers from the LCG with the PC last
        lcg_state = 32'h85bb80ad;
        for (int i = 0; i < `CPU_CTRL_NUM_GPR; i++)
        begin
            lcg_state  = lcg_next(lcg_state);
            exp_gpr[i] = lcg_state;
        end
        lcg_state = lcg_next(lcg_state);
        exp_pc    = lcg_state;
        for (int i = 0; i < `CPU_CTRL_NUM_GPR; i++)
            core_state.gpr[i] = exp_gpr[i];
        core_state.pc = exp_pc;

        repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
        #DRIVE_DLY;
        cache_slv_reg0 = 1'b0;

        test_reset_release();
        test_core_state_reads();
        test_run_control();
        test_reset_control();
        test_unmapped_and_backpressure();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
cpu_ctrl_pkg.sv
axi_lite_slave.sv
ctrl_regmap.sv
core_cmd_sync.sv
cpu_core_controller.sv
cpu_ctrl_sva.sv
tb_cpu_core_controller.sv

/* Makefile */
# Verilator flow for the CPU core controller

VERILATOR ?= verilator
TOP       ?= tb_cpu_core_controller
RTL_TOP   ?= cpu_core_controller
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the binary status alone is not trusted
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
